// File: common/huff_pkg.sv
package huff_pkg;

	// Only symbols 1 to 6 are coded
	localparam int SYM_N = 6;

	// Six symbols never need a code longer than five bits
	localparam int CODE_W = 8;

	typedef logic [7:0] sym_t;

	// Bit k set means symbol k+1 belongs to the item
	typedef logic [SYM_N-1:0] group_t;

	typedef logic [CODE_W-1:0] code_t;

	// Number of items still taking part in the merge
	typedef logic [2:0] item_cnt_t;

	typedef enum logic [2:0] {
		IDLE,
		COUNT,
		COUNT_DONE,
		SORT,
		MERGE,
		DONE
	} ctrl_state_t;

endpackage

// File: common/sort_ctrl_if.sv
`timescale 1ns/1ps

interface sort_ctrl_if import huff_pkg::*;;
	// Strobes from the controller
	logic      load;
	logic      update;

	// Sorter status
	logic      done;
	item_cnt_t active;

	modport ctrl (
		output load,
		output update,
		input  done,
		input  active
	);

	modport sorter (
		input  load,
		input  update,
		output done,
		output active
	);
endinterface

// File: common/pair_if.sv
`timescale 1ns/1ps

interface pair_if import huff_pkg::*; #(
	parameter int CNT_W = 8
);
	// Sorter working registers with the heaviest item in slot 0
	logic [SYM_N-1:0][CNT_W-1:0] weight;
	group_t [SYM_N-1:0]          group;

	// Second-to-last and last active item
	group_t                      group_a;
	group_t                      group_b;

	logic [CNT_W-1:0]            merged_weight;
	group_t                      merged_group;

	modport sorter (output weight, group, input merged_weight, merged_group);
	modport merge (input weight, group, output group_a, group_b, merged_weight, merged_group);
	modport code (input group_a, group_b);
endinterface

// File: rtl/huff_ctrl.sv
`timescale 1ns/1ps

module huff_ctrl import huff_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      gray_valid,
	input  sym_t      gray_data,
	output sym_t      sym_reg,
	output logic      count_en,
	output logic      clear,
	output logic      code_en,
	output logic      cnt_valid,
	output logic      code_valid,
	sort_ctrl_if.ctrl sc
);
	ctrl_state_t state;
	ctrl_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (gray_valid)
					state_nxt = COUNT;
			end
			COUNT: begin
				if (!gray_valid)
					state_nxt = COUNT_DONE;
			end
			COUNT_DONE: state_nxt = SORT;
			SORT: begin
				if (sc.done)
					state_nxt = MERGE;
			end
			// Two items left means this merge forms the root
			MERGE: state_nxt = (sc.active > 3'd2) ? SORT : DONE;
			DONE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Symbol delayed by one cycle so the counter lines up with COUNT
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			sym_reg <= '0;
		else
			sym_reg <= gray_data;
	end

	// Results of the previous burst are wiped as the new one starts
	assign clear      = (state == IDLE) && gray_valid;
	assign count_en   = (state == COUNT);
	assign cnt_valid  = (state == COUNT_DONE);
	assign sc.load    = (state == COUNT_DONE);
	assign sc.update  = (state == MERGE);
	assign code_en    = (state == MERGE);
	assign code_valid = (state == DONE);
endmodule

// File: rtl/symbol_counter.sv
`timescale 1ns/1ps

module symbol_counter import huff_pkg::*; #(
	parameter int CNT_W = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        clear,
	input  logic                        count_en,
	input  sym_t                        sym,
	output logic [SYM_N-1:0][CNT_W-1:0] cnt
);
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt <= '0;
		end else if (clear) begin
			cnt <= '0;
		end else if (count_en) begin
			// Counter k holds symbol value k+1
			for (int k = 0; k < SYM_N; k++) begin
				if (sym == sym_t'(k + 1))
					cnt[k] <= cnt[k] + 1'b1;
			end
		end
	end
endmodule

// File: sorter/odd_even_sorter.sv
`timescale 1ns/1ps

module odd_even_sorter import huff_pkg::*; #(
	parameter int CNT_W = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [SYM_N-1:0][CNT_W-1:0] counts,
	sort_ctrl_if.sorter                 sc,
	pair_if.sorter                      pr
);
	logic [SYM_N-1:0][CNT_W-1:0] weight;
	group_t [SYM_N-1:0]          group;
	logic [SYM_N-1:0][CNT_W-1:0] half_w;
	group_t [SYM_N-1:0]          half_g;
	logic [SYM_N-1:0][CNT_W-1:0] next_w;
	group_t [SYM_N-1:0]          next_g;
	item_cnt_t                   active;
	item_cnt_t                   pass_cnt;

	// One pass is an even phase followed by an odd phase.
	// Equal weights never swap, so ties stay in symbol order.
	always_comb begin
		half_w = weight;
		half_g = group;
		for (int i = 0; i < SYM_N - 1; i += 2) begin
			if (i + 1 < int'(active) && weight[i] < weight[i + 1]) begin
				half_w[i]     = weight[i + 1];
				half_w[i + 1] = weight[i];
				half_g[i]     = group[i + 1];
				half_g[i + 1] = group[i];
			end
		end

		next_w = half_w;
		next_g = half_g;
		for (int i = 1; i < SYM_N - 1; i += 2) begin
			if (i + 1 < int'(active) && half_w[i] < half_w[i + 1]) begin
				next_w[i]     = half_w[i + 1];
				next_w[i + 1] = half_w[i];
				next_g[i]     = half_g[i + 1];
				next_g[i + 1] = half_g[i];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			weight   <= '0;
			group    <= '0;
			active   <= '0;
			pass_cnt <= '0;
		end else if (sc.load) begin
			weight <= counts;
			for (int i = 0; i < SYM_N; i++)
				group[i] <= group_t'(1) << i;
			active   <= item_cnt_t'(SYM_N);
			pass_cnt <= item_cnt_t'(SYM_N - 2);
		end else if (sc.update) begin
			// Merged item replaces the second-to-last slot
			for (int i = 0; i < SYM_N - 1; i++) begin
				if (int'(active) == i + 2) begin
					weight[i] <= pr.merged_weight;
					group[i]  <= pr.merged_group;
				end
			end
			active   <= active - 3'd1;
			pass_cnt <= (active > 3'd3) ? active - 3'd3 : '0;
		end else begin
			weight <= next_w;
			group  <= next_g;
			if (pass_cnt != '0)
				pass_cnt <= pass_cnt - 3'd1;
		end
	end

	assign sc.done   = (pass_cnt == '0);
	assign sc.active = active;
	assign pr.weight = weight;
	assign pr.group  = group;
endmodule

// File: sorter/pair_merge.sv
`timescale 1ns/1ps

module pair_merge import huff_pkg::*; #(
	parameter int CNT_W = 8
) (
	pair_if.merge    pr,
	input item_cnt_t active
);
	logic [CNT_W-1:0] weight_a;
	logic [CNT_W-1:0] weight_b;

	// The two lightest items sit at the bottom of the active range
	always_comb begin
		weight_a   = '0;
		weight_b   = '0;
		pr.group_a = '0;
		pr.group_b = '0;
		for (int i = 0; i < SYM_N - 1; i++) begin
			if (int'(active) == i + 2) begin
				weight_a   = pr.weight[i];
				weight_b   = pr.weight[i + 1];
				pr.group_a = pr.group[i];
				pr.group_b = pr.group[i + 1];
			end
		end
	end

	assign pr.merged_weight = weight_a + weight_b;
	assign pr.merged_group  = pr.group_a | pr.group_b;
endmodule

// File: rtl/code_builder.sv
`timescale 1ns/1ps

module code_builder import huff_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              clear,
	input  logic              en,
	pair_if.code              pr,
	output code_t [SYM_N-1:0] hc,
	output code_t [SYM_N-1:0] mask
);
	// Each merge adds one level above the bits already placed,
	// so the last merge ends up as the leading code bit
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hc   <= '0;
			mask <= '0;
		end else if (clear) begin
			hc   <= '0;
			mask <= '0;
		end else if (en) begin
			for (int k = 0; k < SYM_N; k++) begin
				if (pr.group_a[k] || pr.group_b[k])
					mask[k] <= {mask[k][CODE_W-2:0], 1'b1};
				// mask+1 is the single bit just above the current length
				if (pr.group_b[k])
					hc[k] <= hc[k] | (mask[k] + code_t'(1));
			end
		end
	end
endmodule

// File: rtl/huffman_top.sv
`timescale 1ns/1ps

module huffman_top import huff_pkg::*; #(
	parameter int CNT_W = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        gray_valid,
	input  sym_t                        gray_data,
	output logic                        cnt_valid,
	output logic [SYM_N-1:0][CNT_W-1:0] cnt,
	output logic                        code_valid,
	output code_t [SYM_N-1:0]           hc,
	output code_t [SYM_N-1:0]           mask
);
	sym_t sym_reg;
	logic count_en;
	logic clear;
	logic code_en;

	sort_ctrl_if sc ();
	pair_if #(.CNT_W(CNT_W)) pr ();

	huff_ctrl ctrl0 (
		.clk        (clk),
		.rst        (rst),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.sym_reg    (sym_reg),
		.count_en   (count_en),
		.clear      (clear),
		.code_en    (code_en),
		.cnt_valid  (cnt_valid),
		.code_valid (code_valid),
		.sc         (sc.ctrl)
	);

	symbol_counter #(.CNT_W(CNT_W)) counter0 (
		.clk      (clk),
		.rst      (rst),
		.clear    (clear),
		.count_en (count_en),
		.sym      (sym_reg),
		.cnt      (cnt)
	);

	odd_even_sorter #(.CNT_W(CNT_W)) sorter0 (
		.clk    (clk),
		.rst    (rst),
		.counts (cnt),
		.sc     (sc.sorter),
		.pr     (pr.sorter)
	);

	pair_merge #(.CNT_W(CNT_W)) merge0 (
		.pr     (pr.merge),
		.active (sc.active)
	);

	code_builder code0 (
		.clk   (clk),
		.rst   (rst),
		.clear (clear),
		.en    (code_en),
		.pr    (pr.code),
		.hc    (hc),
		.mask  (mask)
	);
endmodule

// File: verification/huffman_model.svh
// Symbols of the current burst and the expected results
sym_t  burst_q[$];
int    exp_cnt[SYM_N];
int    exp_len[SYM_N];
code_t exp_hc[SYM_N];
code_t exp_mask[SYM_N];

function automatic void count_symbols();
	foreach (exp_cnt[k])
		exp_cnt[k] = 0;
	foreach (burst_q[i]) begin
		if (burst_q[i] >= 1 && burst_q[i] <= SYM_N)
			exp_cnt[burst_q[i] - 1]++;
	end
endfunction

// Repeated stable descending sort, then merge of the two lightest items
function automatic void build_codes();
	int     w[SYM_N];
	group_t g[SYM_N];
	int     n;
	int     tw;
	group_t tg;
	for (int k = 0; k < SYM_N; k++) begin
		w[k] = exp_cnt[k];
		g[k] = group_t'(1) << k;
		exp_hc[k] = '0;
		exp_len[k] = 0;
	end
	n = SYM_N;
	while (n > 1) begin
		for (int i = 1; i < n; i++) begin
			for (int j = i; j > 0; j--) begin
				if (w[j - 1] < w[j]) begin
					tw = w[j - 1];
					w[j - 1] = w[j];
					w[j] = tw;
					tg = g[j - 1];
					g[j - 1] = g[j];
					g[j] = tg;
				end
			end
		end
		// New bit goes above the bits already placed
		for (int k = 0; k < SYM_N; k++) begin
			if (g[n - 1][k])
				exp_hc[k] = exp_hc[k] | (code_t'(1) << exp_len[k]);
			if (g[n - 2][k] || g[n - 1][k])
				exp_len[k]++;
		end
		w[n - 2] = w[n - 2] + w[n - 1];
		g[n - 2] = g[n - 2] | g[n - 1];
		n--;
	end
	for (int k = 0; k < SYM_N; k++)
		exp_mask[k] = (code_t'(1) << exp_len[k]) - code_t'(1);
endfunction

// File: verification/tb_huffman.sv
`timescale 1ns/1ps

module tb_huffman import huff_pkg::*;;

	localparam int CNT_W = 8;
	localparam int BURSTS = 20;
	localparam int MAX_LEN = 40;
	localparam int WAIT_LIMIT = 150;
	localparam int WATCHDOG_NS = BURSTS * 200 * 10;

	logic                        clk;
	logic                        rst;
	logic                        gray_valid;
	sym_t                        gray_data;
	logic                        cnt_valid;
	logic [SYM_N-1:0][CNT_W-1:0] cnt;
	logic                        code_valid;
	code_t [SYM_N-1:0]           hc;
	code_t [SYM_N-1:0]           mask;

	integer seed;
	int     errors;
	int     cnt_pulses;
	int     code_pulses;
	int     len;
	bit     seen;
	logic   prev_cnt_valid;
	logic   prev_code_valid;

	`include "huffman_model.svh"

	huffman_top #(.CNT_W(CNT_W)) dut0 (
		.clk        (clk),
		.rst        (rst),
		.gray_valid (gray_valid),
		.gray_data  (gray_data),
		.cnt_valid  (cnt_valid),
		.cnt        (cnt),
		.code_valid (code_valid),
		.hc         (hc),
		.mask       (mask)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t before all bursts completed", $time);
		$display("CHECKS FAILED");
		$finish;
	end

	// Strobes sampled mid-cycle
	initial begin
		prev_cnt_valid = 1'b0;
		prev_code_valid = 1'b0;
		forever begin
			@(negedge clk);
			if (cnt_valid && prev_cnt_valid) begin
				errors++;
				$display("cnt_valid stayed high for more than one cycle at %0t", $time);
			end
			if (code_valid && prev_code_valid) begin
				errors++;
				$display("code_valid stayed high for more than one cycle at %0t", $time);
			end
			if (code_valid && cnt_pulses == 0) begin
				errors++;
				$display("code_valid arrived before cnt_valid at %0t", $time);
			end
			if (cnt_valid)
				cnt_pulses++;
			if (code_valid)
				code_pulses++;
			prev_cnt_valid = cnt_valid;
			prev_code_valid = code_valid;
		end
	end

	task automatic check_reset_state();
		if (cnt_valid !== 1'b0 || code_valid !== 1'b0 || cnt !== '0 || hc !== '0
			|| mask !== '0) begin
			errors++;
			$display("Mismatch at %0t: outputs not idle and zero after reset", $time);
		end
	endtask

	task automatic send_burst(input int n);
		sym_t s;
		burst_q.delete();
		for (int i = 0; i < n; i++) begin
			s = sym_t'($unsigned($random(seed)) % 8);
			burst_q.push_back(s);
			gray_valid = 1'b1;
			gray_data = s;
			@(posedge clk);
			#1;
		end
		gray_valid = 1'b0;
		gray_data = sym_t'($unsigned($random(seed)));
	endtask

	task automatic wait_strobe(input bit for_code, output bit found);
		int n;
		n = 0;
		found = 1'b0;
		while (!found && n < WAIT_LIMIT) begin
			@(negedge clk);
			found = for_code ? code_valid : cnt_valid;
			n++;
		end
		if (!found) begin
			errors++;
			$display("Gave up at %0t waiting for %s", $time, for_code ? "code_valid" : "cnt_valid");
		end
	endtask

	task automatic check_counts();
		for (int k = 0; k < SYM_N; k++) begin
			if (cnt[k] !== CNT_W'(exp_cnt[k])) begin
				errors++;
				$display("Mismatch at %0t: cnt[%0d] got %0d expected %0d", $time, k, cnt[k],
					exp_cnt[k]);
			end
		end
	endtask

	task automatic check_codes();
		for (int k = 0; k < SYM_N; k++) begin
			if (hc[k] !== exp_hc[k] || mask[k] !== exp_mask[k]) begin
				errors++;
				$display("Mismatch at %0t: symbol %0d code %h/%h expected %h/%h", $time, k + 1,
					hc[k], mask[k], exp_hc[k], exp_mask[k]);
			end
			if ((mask[k] & (mask[k] + code_t'(1))) != '0) begin
				errors++;
				$display("Mismatch at %0t: mask of symbol %0d is not a run from bit 0", $time,
					k + 1);
			end
		end
		// No code may start with another whole code
		for (int i = 0; i < SYM_N; i++) begin
			for (int j = 0; j < SYM_N; j++) begin
				if (i != j && exp_len[i] <= exp_len[j]
					&& (hc[j] >> (exp_len[j] - exp_len[i])) == hc[i]) begin
					errors++;
					$display("Mismatch at %0t: code of symbol %0d is a prefix of symbol %0d",
						$time, i + 1, j + 1);
				end
			end
		end
	endtask

	initial begin
		seed = 32'h8cb8;
		errors = 0;
		cnt_pulses = 0;
		code_pulses = 0;
		rst = 1'b1;
		gray_valid = 1'b0;
		gray_data = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_reset_state();
		end
		@(posedge clk);
		#1;
		for (int b = 0; b < BURSTS; b++) begin
			cnt_pulses = 0;
			code_pulses = 0;
			len = 1 + $unsigned($random(seed)) % MAX_LEN;
			send_burst(len);
			count_symbols();
			build_codes();
			wait_strobe(1'b0, seen);
			if (seen)
				check_counts();
			wait_strobe(1'b1, seen);
			if (seen)
				check_codes();
			repeat (4) @(posedge clk);
			#1;
			if (cnt_pulses != 1 || code_pulses != 1) begin
				errors++;
				$display("Burst %0d gave %0d cnt_valid and %0d code_valid pulses", b,
					cnt_pulses, code_pulses);
			end
		end
		$display("Summary: %0d bursts, %0d errors", BURSTS, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end
endmodule

// File: compile.f
+incdir+verification
common/huff_pkg.sv
common/sort_ctrl_if.sv
common/pair_if.sv
rtl/huff_ctrl.sv
rtl/symbol_counter.sv
sorter/odd_even_sorter.sv
sorter/pair_merge.sv
rtl/code_builder.sv
rtl/huffman_top.sv
verification/tb_huffman.sv
